// ==== logic/tcdm_group_pkg.sv ====
// ********************
// Geometry of one group. NumTiles and RowsPerBank must be powers of two
// and the group select is a single address bit
// ********************

package tcdm_group_pkg;

  localparam int unsigned NumTiles    = 4;
  localparam int unsigned NumGroups   = 2;
  localparam int unsigned RowsPerBank = 16;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = DataWidth / 8;

  localparam int unsigned TileIdxWidth = $clog2(NumTiles);
  localparam int unsigned RowWidth     = $clog2(RowsPerBank);
  localparam int unsigned GroupWidth   = $clog2(NumGroups);
  localparam int unsigned OffsetWidth  = RowWidth + TileIdxWidth;

  typedef logic [TileIdxWidth-1:0] tile_idx_t;
  typedef logic [RowWidth-1:0]     row_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [GroupWidth-1:0]   group_id_t;
  typedef logic [OffsetWidth-1:0]  offset_t;

  // Word address, group bit on top in both views
  typedef union packed {
    // Tile index in the low bits interleaves words over the banks
    struct packed {
      group_id_t group;
      row_t      row;
      tile_idx_t tile;
    } local_v;
    // Offset is opaque to this group and forwarded as is
    struct packed {
      group_id_t group;
      offset_t   offset;
    } remote_v;
  } tcdm_addr_u;

endpackage

// ==== logic/tcdm_local_xbar.sv ====
// ********************
// Banks always accept, so a local grant is the master's ready
// Masters must hold their request while ready is low
// ********************

`timescale 1ns/100ps

module tcdm_local_xbar #(
  parameter int unsigned               NumTiles = tcdm_group_pkg::NumTiles,
  parameter tcdm_group_pkg::group_id_t GroupId  = '0
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                       [NumTiles-1:0] mst_req_valid_i,
  output logic                       [NumTiles-1:0] mst_req_ready_o,
  input  tcdm_group_pkg::tcdm_addr_u [NumTiles-1:0] mst_req_addr_i,
  input  logic                       [NumTiles-1:0] mst_req_wen_i,
  input  tcdm_group_pkg::data_t      [NumTiles-1:0] mst_req_wdata_i,
  input  tcdm_group_pkg::be_t        [NumTiles-1:0] mst_req_be_i,
  output logic                       [NumTiles-1:0] rmt_req_valid_o,
  input  logic                       [NumTiles-1:0] rmt_req_ready_i,
  output logic                       [NumTiles-1:0] bank_req_valid_o,
  output tcdm_group_pkg::row_t       [NumTiles-1:0] bank_req_row_o,
  output tcdm_group_pkg::tile_idx_t  [NumTiles-1:0] bank_req_ini_o,
  output logic                       [NumTiles-1:0] bank_req_wen_o,
  output tcdm_group_pkg::data_t      [NumTiles-1:0] bank_req_wdata_o,
  output tcdm_group_pkg::be_t        [NumTiles-1:0] bank_req_be_o
);

  import tcdm_group_pkg::*;

  logic [NumTiles-1:0]               local_req;
  logic [NumTiles-1:0]               local_gnt;
  logic [NumTiles-1:0][NumTiles-1:0] gnt;

  // Group bit decides the path
  for (genvar m = 0; m < NumTiles; m++) begin : gen_split
    assign local_req[m] = mst_req_valid_i[m] &&
                          (mst_req_addr_i[m].local_v.group == GroupId);
    assign rmt_req_valid_o[m] = mst_req_valid_i[m] &&
                                (mst_req_addr_i[m].local_v.group != GroupId);
  end

  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    logic [NumTiles-1:0] req;
    logic [NumTiles-1:0] gnt_b;
    logic                win_vld;
    tile_idx_t           win_idx;
    tile_idx_t           rr_q;

    for (genvar m = 0; m < NumTiles; m++) begin : gen_req
      assign req[m] = local_req[m] && (mst_req_addr_i[m].local_v.tile == tile_idx_t'(b));
    end

    // First requester at or after the pointer wins
    always_comb begin
      tile_idx_t idx;
      idx     = '0;
      win_vld = 1'b0;
      win_idx = rr_q;
      gnt_b   = '0;
      for (int i = 0; i < NumTiles; i++) begin
        idx = tile_idx_t'((int'(rr_q) + i) % NumTiles);
        if (!win_vld && req[idx]) begin
          win_vld = 1'b1;
          win_idx = idx;
        end
      end
      gnt_b[win_idx] = win_vld;
    end

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        rr_q <= '0;
      end else if (win_vld) begin
        rr_q <= tile_idx_t'((int'(win_idx) + 1) % NumTiles);
      end
    end

    assign gnt[b]              = gnt_b;
    assign bank_req_valid_o[b] = win_vld;
    assign bank_req_row_o[b]   = mst_req_addr_i[win_idx].local_v.row;
    assign bank_req_ini_o[b]   = win_idx;
    assign bank_req_wen_o[b]   = mst_req_wen_i[win_idx];
    assign bank_req_wdata_o[b] = mst_req_wdata_i[win_idx];
    assign bank_req_be_o[b]    = mst_req_be_i[win_idx];

    // Remote ready must never leak to a local requester of this bank
    a_one_hs_per_bank: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(req & mst_req_ready_o))
      else $error("more than one handshake on bank %0d", b);
  end

  always_comb begin
    local_gnt = '0;
    for (int m = 0; m < NumTiles; m++) begin
      for (int b = 0; b < NumTiles; b++) begin
        local_gnt[m] = local_gnt[m] | gnt[b][m];
      end
    end
  end

  assign mst_req_ready_o = local_gnt | rmt_req_ready_i;

endmodule

// ==== logic/tcdm_bank_array.sv ====
// ********************
// Response one cycle after the request, writes return the new word
// Valid follows the request, so reset needs idle masters
// ********************

`timescale 1ns/100ps

module tcdm_bank_array #(
  parameter int unsigned NumTiles = tcdm_group_pkg::NumTiles
) (
  input  logic                                     clk_i,
  input  logic                      [NumTiles-1:0] bank_req_valid_i,
  input  tcdm_group_pkg::row_t      [NumTiles-1:0] bank_req_row_i,
  input  tcdm_group_pkg::tile_idx_t [NumTiles-1:0] bank_req_ini_i,
  input  logic                      [NumTiles-1:0] bank_req_wen_i,
  input  tcdm_group_pkg::data_t     [NumTiles-1:0] bank_req_wdata_i,
  input  tcdm_group_pkg::be_t       [NumTiles-1:0] bank_req_be_i,
  output logic                      [NumTiles-1:0] bank_resp_valid_o,
  output tcdm_group_pkg::tile_idx_t [NumTiles-1:0] bank_resp_ini_o,
  output tcdm_group_pkg::data_t     [NumTiles-1:0] bank_resp_rdata_o
);

  import tcdm_group_pkg::*;

  for (genvar b = 0; b < NumTiles; b++) begin : gen_bank
    data_t     mem_q [RowsPerBank];
    data_t     wr_word;
    logic      resp_valid_q;
    tile_idx_t resp_ini_q;
    data_t     resp_rdata_q;

    // Byte merge of the stored word
    always_comb begin
      wr_word = mem_q[bank_req_row_i[b]];
      for (int j = 0; j < BeWidth; j++) begin
        if (bank_req_be_i[b][j]) begin
          wr_word[8*j +: 8] = bank_req_wdata_i[b][8*j +: 8];
        end
      end
    end

    always_ff @(posedge clk_i) begin
      resp_valid_q <= bank_req_valid_i[b];
      if (bank_req_valid_i[b]) begin
        resp_ini_q <= bank_req_ini_i[b];
        if (bank_req_wen_i[b]) begin
          mem_q[bank_req_row_i[b]] <= wr_word;
          resp_rdata_q             <= wr_word;
        end else begin
          resp_rdata_q <= mem_q[bank_req_row_i[b]];
        end
      end
    end

    assign bank_resp_valid_o[b] = resp_valid_q;
    assign bank_resp_ini_o[b]   = resp_ini_q;
    assign bank_resp_rdata_o[b] = resp_rdata_q;
  end

endmodule

// ==== logic/tcdm_east_port.sv ====
// ********************
// One request register toward the east, refilled only when empty or draining
// Payload stays stable while east ready is low
// ********************

`timescale 1ns/100ps

module tcdm_east_port #(
  parameter int unsigned               NumTiles = tcdm_group_pkg::NumTiles,
  parameter tcdm_group_pkg::group_id_t GroupId  = '0
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                       [NumTiles-1:0] rmt_req_valid_i,
  output logic                       [NumTiles-1:0] rmt_req_ready_o,
  input  tcdm_group_pkg::tcdm_addr_u [NumTiles-1:0] mst_req_addr_i,
  input  logic                       [NumTiles-1:0] mst_req_wen_i,
  input  tcdm_group_pkg::data_t      [NumTiles-1:0] mst_req_wdata_i,
  input  tcdm_group_pkg::be_t        [NumTiles-1:0] mst_req_be_i,
  output logic                                      east_req_valid_o,
  input  logic                                      east_req_ready_i,
  output tcdm_group_pkg::offset_t                   east_req_offset_o,
  output tcdm_group_pkg::tile_idx_t                 east_req_ini_o,
  output logic                                      east_req_wen_o,
  output tcdm_group_pkg::data_t                     east_req_wdata_o,
  output tcdm_group_pkg::be_t                       east_req_be_o
);

  import tcdm_group_pkg::*;

  logic                win_vld;
  tile_idx_t           win_idx;
  logic [NumTiles-1:0] gnt;
  logic                can_load;
  logic                load;
  tile_idx_t           rr_q;
  logic                valid_q;
  tcdm_addr_u          addr_q;
  tile_idx_t           ini_q;
  logic                wen_q;
  data_t               wdata_q;
  be_t                 be_q;

  always_comb begin
    tile_idx_t idx;
    idx     = '0;
    win_vld = 1'b0;
    win_idx = rr_q;
    gnt     = '0;
    for (int i = 0; i < NumTiles; i++) begin
      idx = tile_idx_t'((int'(rr_q) + i) % NumTiles);
      if (!win_vld && rmt_req_valid_i[idx]) begin
        win_vld = 1'b1;
        win_idx = idx;
      end
    end
    gnt[win_idx] = win_vld;
  end

  assign can_load        = !valid_q || east_req_ready_i;
  assign load            = win_vld && can_load;
  assign rmt_req_ready_o = gnt & {NumTiles{can_load}};

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      rr_q    <= '0;
    end else begin
      if (load) begin
        valid_q <= 1'b1;
        rr_q    <= tile_idx_t'((int'(win_idx) + 1) % NumTiles);
      end else if (east_req_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      addr_q  <= mst_req_addr_i[win_idx];
      ini_q   <= win_idx;
      wen_q   <= mst_req_wen_i[win_idx];
      wdata_q <= mst_req_wdata_i[win_idx];
      be_q    <= mst_req_be_i[win_idx];
    end
  end

  assign east_req_valid_o  = valid_q;
  assign east_req_offset_o = addr_q.remote_v.offset;
  assign east_req_ini_o    = ini_q;
  assign east_req_wen_o    = wen_q;
  assign east_req_wdata_o  = wdata_q;
  assign east_req_be_o     = be_q;

  // Held request is stable and really belongs to the other group
  a_east_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    east_req_valid_o && !east_req_ready_i |=> east_req_valid_o && $stable(addr_q) &&
    $stable(ini_q) && $stable(wen_q) && $stable(wdata_q) && $stable(be_q) &&
    (addr_q.remote_v.group != GroupId))
    else $error("east request changed under back-pressure");

endmodule

// ==== logic/tcdm_resp_merge.sv ====
// ********************
// Masters always take responses; a bank response wins over the east one
// ********************

`timescale 1ns/100ps

module tcdm_resp_merge #(
  parameter int unsigned NumTiles = tcdm_group_pkg::NumTiles
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic                      [NumTiles-1:0] bank_resp_valid_i,
  input  tcdm_group_pkg::tile_idx_t [NumTiles-1:0] bank_resp_ini_i,
  input  tcdm_group_pkg::data_t     [NumTiles-1:0] bank_resp_rdata_i,
  input  logic                                     east_resp_valid_i,
  output logic                                     east_resp_ready_o,
  input  tcdm_group_pkg::tile_idx_t                east_resp_ini_i,
  input  tcdm_group_pkg::data_t                    east_resp_rdata_i,
  output logic                      [NumTiles-1:0] mst_resp_valid_o,
  output tcdm_group_pkg::data_t     [NumTiles-1:0] mst_resp_rdata_o
);

  import tcdm_group_pkg::*;

  logic  [NumTiles-1:0][NumTiles-1:0] hit_mat;
  logic  [NumTiles-1:0]               bank_hit;
  data_t [NumTiles-1:0]               bank_rdata;

  // Initiator tag decode, row per master
  always_comb begin
    hit_mat    = '0;
    bank_hit   = '0;
    bank_rdata = '0;
    for (int m = 0; m < NumTiles; m++) begin
      for (int b = 0; b < NumTiles; b++) begin
        hit_mat[m][b] = bank_resp_valid_i[b] && (bank_resp_ini_i[b] == tile_idx_t'(m));
        if (hit_mat[m][b]) begin
          bank_hit[m]   = 1'b1;
          bank_rdata[m] = bank_resp_rdata_i[b];
        end
      end
    end
  end

  assign east_resp_ready_o = east_resp_valid_i && !bank_hit[east_resp_ini_i];

  for (genvar m = 0; m < NumTiles; m++) begin : gen_mst
    assign mst_resp_valid_o[m] = bank_hit[m] ||
                                 (east_resp_ready_o && (east_resp_ini_i == tile_idx_t'(m)));
    assign mst_resp_rdata_o[m] = bank_hit[m] ? bank_rdata[m] : east_resp_rdata_i;

    // Crossbar grants one bank per master per cycle
    a_one_bank_resp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(hit_mat[m]))
      else $error("master %0d got two bank responses", m);
  end

endmodule

// ==== logic/tcdm_group.sv ====
// ********************
// One group: local banks plus the east channel toward the other group
// ********************

`timescale 1ns/100ps

module tcdm_group #(
  parameter int unsigned               NumTiles = tcdm_group_pkg::NumTiles,
  parameter tcdm_group_pkg::group_id_t GroupId  = '0
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Masters
  input  logic                       [NumTiles-1:0] mst_req_valid_i,
  output logic                       [NumTiles-1:0] mst_req_ready_o,
  input  tcdm_group_pkg::tcdm_addr_u [NumTiles-1:0] mst_req_addr_i,
  input  logic                       [NumTiles-1:0] mst_req_wen_i,
  input  tcdm_group_pkg::data_t      [NumTiles-1:0] mst_req_wdata_i,
  input  tcdm_group_pkg::be_t        [NumTiles-1:0] mst_req_be_i,
  output logic                       [NumTiles-1:0] mst_resp_valid_o,
  output tcdm_group_pkg::data_t      [NumTiles-1:0] mst_resp_rdata_o,
  // East channel
  output logic                                      east_req_valid_o,
  input  logic                                      east_req_ready_i,
  output tcdm_group_pkg::offset_t                   east_req_offset_o,
  output tcdm_group_pkg::tile_idx_t                 east_req_ini_o,
  output logic                                      east_req_wen_o,
  output tcdm_group_pkg::data_t                     east_req_wdata_o,
  output tcdm_group_pkg::be_t                       east_req_be_o,
  input  logic                                      east_resp_valid_i,
  output logic                                      east_resp_ready_o,
  input  tcdm_group_pkg::tile_idx_t                 east_resp_ini_i,
  input  tcdm_group_pkg::data_t                     east_resp_rdata_i
);

  import tcdm_group_pkg::*;

  logic      [NumTiles-1:0] rmt_req_valid;
  logic      [NumTiles-1:0] rmt_req_ready;
  logic      [NumTiles-1:0] bank_req_valid;
  row_t      [NumTiles-1:0] bank_req_row;
  tile_idx_t [NumTiles-1:0] bank_req_ini;
  logic      [NumTiles-1:0] bank_req_wen;
  data_t     [NumTiles-1:0] bank_req_wdata;
  be_t       [NumTiles-1:0] bank_req_be;
  logic      [NumTiles-1:0] bank_resp_valid;
  tile_idx_t [NumTiles-1:0] bank_resp_ini;
  data_t     [NumTiles-1:0] bank_resp_rdata;

  tcdm_local_xbar #(
    .NumTiles(NumTiles),
    .GroupId (GroupId )
  ) i_local_xbar (
    .clk_i           (clk_i          ),
    .rst_n_i         (rst_n_i        ),
    .mst_req_valid_i (mst_req_valid_i),
    .mst_req_ready_o (mst_req_ready_o),
    .mst_req_addr_i  (mst_req_addr_i ),
    .mst_req_wen_i   (mst_req_wen_i  ),
    .mst_req_wdata_i (mst_req_wdata_i),
    .mst_req_be_i    (mst_req_be_i   ),
    .rmt_req_valid_o (rmt_req_valid  ),
    .rmt_req_ready_i (rmt_req_ready  ),
    .bank_req_valid_o(bank_req_valid ),
    .bank_req_row_o  (bank_req_row   ),
    .bank_req_ini_o  (bank_req_ini   ),
    .bank_req_wen_o  (bank_req_wen   ),
    .bank_req_wdata_o(bank_req_wdata ),
    .bank_req_be_o   (bank_req_be    )
  );

  tcdm_bank_array #(
    .NumTiles(NumTiles)
  ) i_bank_array (
    .clk_i            (clk_i          ),
    .bank_req_valid_i (bank_req_valid ),
    .bank_req_row_i   (bank_req_row   ),
    .bank_req_ini_i   (bank_req_ini   ),
    .bank_req_wen_i   (bank_req_wen   ),
    .bank_req_wdata_i (bank_req_wdata ),
    .bank_req_be_i    (bank_req_be    ),
    .bank_resp_valid_o(bank_resp_valid),
    .bank_resp_ini_o  (bank_resp_ini  ),
    .bank_resp_rdata_o(bank_resp_rdata)
  );

  tcdm_east_port #(
    .NumTiles(NumTiles),
    .GroupId (GroupId )
  ) i_east_port (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .rmt_req_valid_i  (rmt_req_valid    ),
    .rmt_req_ready_o  (rmt_req_ready    ),
    .mst_req_addr_i   (mst_req_addr_i   ),
    .mst_req_wen_i    (mst_req_wen_i    ),
    .mst_req_wdata_i  (mst_req_wdata_i  ),
    .mst_req_be_i     (mst_req_be_i     ),
    .east_req_valid_o (east_req_valid_o ),
    .east_req_ready_i (east_req_ready_i ),
    .east_req_offset_o(east_req_offset_o),
    .east_req_ini_o   (east_req_ini_o   ),
    .east_req_wen_o   (east_req_wen_o   ),
    .east_req_wdata_o (east_req_wdata_o ),
    .east_req_be_o    (east_req_be_o    )
  );

  tcdm_resp_merge #(
    .NumTiles(NumTiles)
  ) i_resp_merge (
    .clk_i            (clk_i            ),
    .rst_n_i          (rst_n_i          ),
    .bank_resp_valid_i(bank_resp_valid  ),
    .bank_resp_ini_i  (bank_resp_ini    ),
    .bank_resp_rdata_i(bank_resp_rdata  ),
    .east_resp_valid_i(east_resp_valid_i),
    .east_resp_ready_o(east_resp_ready_o),
    .east_resp_ini_i  (east_resp_ini_i  ),
    .east_resp_rdata_i(east_resp_rdata_i),
    .mst_resp_valid_o (mst_resp_valid_o ),
    .mst_resp_rdata_o (mst_resp_rdata_o )
  );

endmodule

// ==== testbench/tcdm_group_tb.sv ====
// ********************
// Testbench for group 0. Each master has at most one request in flight
// Bank words are read only after the table has written them
// ********************

`timescale 1ns/100ps

module tcdm_group_tb;

  import tcdm_group_pkg::*;

  localparam int        TblLen      = 19;
  localparam int        CycleLimit  = 20 * TblLen + 50;
  localparam group_id_t GroupId     = 1'b0;
  localparam int        KindLocal   = 0;
  localparam int        KindPair    = 1;
  localparam int        KindRemote  = 2;
  localparam int        KindCollide = 3;
  localparam int        KindPart    = 4;

  logic                       clk_i = 1'b0;
  logic                       rst_n_i;
  logic       [NumTiles-1:0]  mst_req_valid_i;
  logic       [NumTiles-1:0]  mst_req_ready_o;
  tcdm_addr_u [NumTiles-1:0]  mst_req_addr_i;
  logic       [NumTiles-1:0]  mst_req_wen_i;
  data_t      [NumTiles-1:0]  mst_req_wdata_i;
  be_t        [NumTiles-1:0]  mst_req_be_i;
  logic       [NumTiles-1:0]  mst_resp_valid_o;
  data_t      [NumTiles-1:0]  mst_resp_rdata_o;
  logic                       east_req_valid_o;
  logic                       east_req_ready_i;
  offset_t                    east_req_offset_o;
  tile_idx_t                  east_req_ini_o;
  logic                       east_req_wen_o;
  data_t                      east_req_wdata_o;
  be_t                        east_req_be_o;
  logic                       east_resp_valid_i;
  logic                       east_resp_ready_o;
  tile_idx_t                  east_resp_ini_i;
  data_t                      east_resp_rdata_i;

  // Stimulus table, one row per access
  int         tbl_kind  [TblLen];
  int         tbl_mst   [TblLen];
  tcdm_addr_u tbl_addr  [TblLen];
  logic       tbl_wen   [TblLen];
  data_t      tbl_wdata [TblLen];
  be_t        tbl_be    [TblLen];
  int         tbl_cnt   = 0;

  data_t       loc_mem [2**OffsetWidth];
  data_t       rmt_mem [2**OffsetWidth];
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          e;

  tcdm_group #(
    .NumTiles(NumTiles),
    .GroupId (GroupId )
  ) tcdm_group_i (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CycleLimit) begin
      $display("Run did not finish within %0d cycles", CycleLimit);
      $display(">>> FAIL");
      $fatal(1, "timeout");
    end
  end

  function automatic data_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
    data_t res;
    res = old;
    for (int j = 0; j < BeWidth; j++) begin
      if (be[j]) res[8*j +: 8] = wdata[8*j +: 8];
    end
    return res;
  endfunction

  function automatic tcdm_addr_u local_addr(input row_t row, input tile_idx_t tile);
    tcdm_addr_u a;
    a.local_v.group = GroupId;
    a.local_v.row   = row;
    a.local_v.tile  = tile;
    return a;
  endfunction

  function automatic tcdm_addr_u remote_addr(input offset_t off);
    tcdm_addr_u a;
    a.remote_v.group  = ~GroupId;
    a.remote_v.offset = off;
    return a;
  endfunction

  // Memory models, updated when the access is accepted
  function automatic data_t local_access(input int n);
    logic [OffsetWidth-1:0] idx;
    idx = {tbl_addr[n].local_v.row, tbl_addr[n].local_v.tile};
    if (tbl_wen[n]) loc_mem[idx] = merge_bytes(loc_mem[idx], tbl_wdata[n], tbl_be[n]);
    return loc_mem[idx];
  endfunction

  function automatic data_t remote_access(input int n);
    offset_t idx;
    idx = tbl_addr[n].remote_v.offset;
    if (tbl_wen[n]) rmt_mem[idx] = merge_bytes(rmt_mem[idx], tbl_wdata[n], tbl_be[n]);
    return rmt_mem[idx];
  endfunction

  task automatic add_entry(input int kind, input int mst, input tcdm_addr_u addr,
                           input logic wen, input be_t be);
    tbl_kind[tbl_cnt]  = kind;
    tbl_mst[tbl_cnt]   = mst;
    tbl_addr[tbl_cnt]  = addr;
    tbl_wen[tbl_cnt]   = wen;
    tbl_wdata[tbl_cnt] = lcg_next();
    tbl_be[tbl_cnt]    = be;
    tbl_cnt++;
  endtask

  task automatic report_mismatch(input string name, input string got, input string exp);
    $display("FAILED at %0t: %s is %s, expected %s", $time, name, got, exp);
    $display(">>> FAIL");
    $fatal(1, "value mismatch");
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_ini(input string name, input tile_idx_t got, input tile_idx_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic check_offset(input string name, input offset_t got, input offset_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
  endtask

  task automatic check_be(input string name, input be_t got, input be_t exp);
    if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic drive_req(input int n);
    mst_req_valid_i[tbl_mst[n]] = 1'b1;
    mst_req_addr_i[tbl_mst[n]]  = tbl_addr[n];
    mst_req_wen_i[tbl_mst[n]]   = tbl_wen[n];
    mst_req_wdata_i[tbl_mst[n]] = tbl_wdata[n];
    mst_req_be_i[tbl_mst[n]]    = tbl_be[n];
  endtask

  // Called at a falling edge, returns just after the handshake edge
  task automatic wait_grant(input int m);
    while (!mst_req_ready_o[m]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_east_req(input int n);
    check_bit("east_req_valid_o", east_req_valid_o, 1'b1);
    check_offset("east_req_offset_o", east_req_offset_o, tbl_addr[n].remote_v.offset);
    check_ini("east_req_ini_o", east_req_ini_o, tile_idx_t'(tbl_mst[n]));
    check_bit("east_req_wen_o", east_req_wen_o, tbl_wen[n]);
    check_data("east_req_wdata_o", east_req_wdata_o, tbl_wdata[n]);
    check_be("east_req_be_o", east_req_be_o, tbl_be[n]);
  endtask

  // One or two local accesses, each response exactly one cycle after its handshake
  task automatic run_local(input int ea, input int eb, input logic pair);
    logic  [NumTiles-1:0] active;
    logic  [NumTiles-1:0] pend;
    logic  [NumTiles-1:0] hs;
    data_t [NumTiles-1:0] exp_rd;
    int                   ent [NumTiles];
    logic                 first;
    active = '0;
    pend   = '0;
    exp_rd = '0;
    first  = 1'b1;
    @(posedge clk_i);
    #1;
    drive_req(ea);
    active[tbl_mst[ea]] = 1'b1;
    ent[tbl_mst[ea]]    = ea;
    if (pair) begin
      drive_req(eb);
      active[tbl_mst[eb]] = 1'b1;
      ent[tbl_mst[eb]]    = eb;
    end
    while (|(active | pend)) begin
      @(negedge clk_i);
      hs = active & mst_req_ready_o;
      for (int m = 0; m < NumTiles; m++) begin
        check_bit($sformatf("mst_resp_valid_o[%0d]", m), mst_resp_valid_o[m], pend[m]);
        if (pend[m]) check_data($sformatf("mst_resp_rdata_o[%0d]", m), mst_resp_rdata_o[m],
                                exp_rd[m]);
      end
      if (pair && first) check_bit("single bank grant", $countones(hs) == 1, 1'b1);
      first = 1'b0;
      pend  = '0;
      @(posedge clk_i);
      #1;
      for (int m = 0; m < NumTiles; m++) begin
        if (hs[m]) begin
          exp_rd[m]          = local_access(ent[m]);
          pend[m]            = 1'b1;
          active[m]          = 1'b0;
          mst_req_valid_i[m] = 1'b0;
        end
      end
    end
  endtask

  // Remote access, optionally with a local read whose response meets the east one
  task automatic run_remote(input int n, input int c, input logic collide);
    int    m;
    data_t rmt_rd;
    data_t loc_rd;
    m = tbl_mst[n];
    @(posedge clk_i);
    #1;
    drive_req(n);
    @(negedge clk_i);
    check_bit("east_req_valid_o", east_req_valid_o, 1'b0);
    wait_grant(m);
    mst_req_valid_i[m] = 1'b0;
    // East ready held low for three cycles
    for (int k = 0; k < 3; k++) begin
      @(negedge clk_i);
      check_east_req(n);
    end
    @(posedge clk_i);
    #1;
    east_req_ready_i = 1'b1;
    @(posedge clk_i);
    #1;
    east_req_ready_i = 1'b0;
    @(negedge clk_i);
    check_bit("east_req_valid_o", east_req_valid_o, 1'b0);
    rmt_rd = remote_access(n);
    @(posedge clk_i);
    #1;
    if (collide) begin
      drive_req(c);
      @(negedge clk_i);
      wait_grant(m);
      mst_req_valid_i[m] = 1'b0;
      loc_rd             = local_access(c);
    end
    east_resp_valid_i = 1'b1;
    east_resp_ini_i   = tile_idx_t'(m);
    east_resp_rdata_i = rmt_rd;
    if (collide) begin
      @(negedge clk_i);
      check_bit("east_resp_ready_o", east_resp_ready_o, 1'b0);
      check_bit($sformatf("mst_resp_valid_o[%0d]", m), mst_resp_valid_o[m], 1'b1);
      check_data($sformatf("mst_resp_rdata_o[%0d]", m), mst_resp_rdata_o[m], loc_rd);
    end
    @(negedge clk_i);
    check_bit("east_resp_ready_o", east_resp_ready_o, 1'b1);
    check_bit($sformatf("mst_resp_valid_o[%0d]", m), mst_resp_valid_o[m], 1'b1);
    check_data($sformatf("mst_resp_rdata_o[%0d]", m), mst_resp_rdata_o[m], rmt_rd);
    @(posedge clk_i);
    #1;
    east_resp_valid_i = 1'b0;
  endtask

  initial begin
    rst_n_i           = 1'b0;
    mst_req_valid_i   = '0;
    mst_req_addr_i    = '0;
    mst_req_wen_i     = '0;
    mst_req_wdata_i   = '0;
    mst_req_be_i      = '0;
    east_req_ready_i  = 1'b0;
    east_resp_valid_i = 1'b0;
    east_resp_ini_i   = '0;
    east_resp_rdata_i = '0;
    lcg_state         = 32'h5976b058;
    for (int i = 0; i < 2**OffsetWidth; i++) begin
      rmt_mem[i] = 32'h5a00_0000 ^ (data_t'(i) * 32'h0001_0203);
    end
    add_entry(KindLocal,   0, local_addr(4'd3, 2'd1), 1'b1, 4'hf);
    add_entry(KindLocal,   2, local_addr(4'd3, 2'd1), 1'b0, 4'hf);
    add_entry(KindLocal,   1, local_addr(4'd5, 2'd2), 1'b1, 4'hf);
    add_entry(KindLocal,   3, local_addr(4'd5, 2'd2), 1'b1, 4'b0101);
    add_entry(KindLocal,   0, local_addr(4'd5, 2'd2), 1'b0, 4'hf);
    add_entry(KindPair,    1, local_addr(4'd7, 2'd0), 1'b1, 4'hf);
    add_entry(KindPart,    3, local_addr(4'd9, 2'd0), 1'b1, 4'hf);
    add_entry(KindPair,    2, local_addr(4'd7, 2'd0), 1'b0, 4'hf);
    add_entry(KindPart,    0, local_addr(4'd9, 2'd0), 1'b0, 4'hf);
    add_entry(KindPair,    2, local_addr(4'd2, 2'd3), 1'b1, 4'hf);
    add_entry(KindPart,    1, local_addr(4'd2, 2'd3), 1'b1, 4'hf);
    add_entry(KindLocal,   3, local_addr(4'd2, 2'd3), 1'b0, 4'hf);
    add_entry(KindRemote,  1, remote_addr(6'h15), 1'b1, 4'hf);
    add_entry(KindRemote,  2, remote_addr(6'h15), 1'b0, 4'hf);
    add_entry(KindRemote,  3, remote_addr(6'h2a), 1'b0, 4'hf);
    add_entry(KindCollide, 0, remote_addr(6'h0c), 1'b0, 4'hf);
    add_entry(KindPart,    0, local_addr(4'd3, 2'd1), 1'b0, 4'hf);
    add_entry(KindRemote,  0, remote_addr(6'h0c), 1'b1, 4'b1001);
    add_entry(KindRemote,  2, remote_addr(6'h0c), 1'b0, 4'hf);
    repeat (2) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    e = 0;
    while (e < tbl_cnt) begin
      case (tbl_kind[e])
        KindLocal:   run_local(e, e, 1'b0);
        KindPair:    run_local(e, e + 1, 1'b1);
        KindRemote:  run_remote(e, e, 1'b0);
        KindCollide: run_remote(e, e + 1, 1'b1);
        default: begin
          $display("Table entry %0d has no valid kind", e);
          $display(">>> FAIL");
          $fatal(1, "bad table");
        end
      endcase
      e += (tbl_kind[e] == KindPair || tbl_kind[e] == KindCollide) ? 2 : 1;
    end
    repeat (2) @(posedge clk_i);
    if (tbl_cnt != TblLen || e != TblLen) begin
      $display("Only %0d of %0d table entries were applied", e, TblLen);
      $display(">>> FAIL");
      $fatal(1, "incomplete run");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== vlog.f ====
logic/tcdm_group_pkg.sv
logic/tcdm_local_xbar.sv
logic/tcdm_bank_array.sv
logic/tcdm_east_port.sv
logic/tcdm_resp_merge.sv
logic/tcdm_group.sv
testbench/tcdm_group_tb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --timing --assert -j 0
TOP      ?= tcdm_group_tb
RTL_TOP  ?= tcdm_group
FILELIST ?= vlog.f
OBJ_DIR  ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(TOOL) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
